// File: Makefile
sim:
	verilator --binary --assert -j 0 --top-module tb_mvblck -f compile.f
	./obj_dir/Vtb_mvblck | tee sim.log
	@if grep -q "Finished with errors" sim.log; then exit 1; fi
	@grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log

// File: block_mover.sv
// *********************************************************************
// LSAB to DRAM block mover
// *********************************************************************
`timescale 1ns/10ps
`include "lsab_consts.svh"

module block_mover
(
	input  logic CLK,
	input  logic RST,
	input  logic cmd_valid,
	input  logic [`LSAB_ADDR_W-1:0] cmd_addr,
	input  logic [`LSAB_COUNT_W-1:0] cmd_count,
	input  logic [`LSAB_SECT_W-1:0] cmd_section,
	output logic cmd_ready,
	output logic [`LSAB_SECT_W-1:0] rd_section,
	output logic rd_en,
	input  lsab_pkg::lsab_entry_t rd_entry,
	input  logic rd_empty,
	output logic req_valid,
	output logic [`LSAB_ADDR_W-1:0] req_addr,
	output logic [2*`LSAB_DATA_W-1:0] req_data,
	output logic [3:0] req_be,
	input  logic req_ready,
	output logic done_valid,
	output lsab_pkg::mover_done_t done,
	input  logic done_ready
);

	typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_REPORT} state_t;

	state_t state;
	logic live;
	logic [`LSAB_ADDR_W-1:0] cur_addr;
	logic [`LSAB_COUNT_W-1:0] left;
	logic [`LSAB_COUNT_W-1:0] sent;
	logic abrupt_q;
	// even-address word waiting for its odd partner
	logic half_valid;
	logic [`LSAB_DATA_W-1:0] half_data;
	logic last_intr;
	logic [`LSAB_ANCILL_W-1:0] last_ancill;
	logic read_due;
	logic stop_now;
	logic block_over;
	logic flush_now;
	logic finish_now;

	assign cmd_ready = live && (state == ST_IDLE);

	// a read is due only while the request register is free
	assign read_due = (state == ST_RUN) && (left != '0) && !abrupt_q && !req_valid;
	assign rd_en = read_due && !rd_empty;
	// an empty section only ends the block once a word has gone out
	assign stop_now = read_due && rd_empty && (sent != '0);

	assign block_over = (state == ST_RUN) && ((left == '0) || abrupt_q);
	assign flush_now = block_over && half_valid && !req_valid;
	assign finish_now = block_over && !half_valid && !req_valid;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			state <= ST_IDLE;
			live <= 1'b0;
			left <= '0;
			abrupt_q <= 1'b0;
			half_valid <= 1'b0;
			req_valid <= 1'b0;
		end
		else
		begin
			live <= 1'b1;
			if (req_valid && req_ready)
				req_valid <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (cmd_valid && cmd_ready)
					begin
						state <= ST_RUN;
						left <= cmd_count;
						abrupt_q <= 1'b0;
						half_valid <= 1'b0;
					end
				end
				ST_RUN:
				begin
					if (rd_en)
					begin
						left <= left - 1'b1;
						// odd address completes a pair
						req_valid <= cur_addr[0];
						half_valid <= !cur_addr[0];
					end
					else if (stop_now)
						abrupt_q <= 1'b1;
					else if (flush_now)
					begin
						req_valid <= 1'b1;
						half_valid <= 1'b0;
					end
					else if (finish_now)
						state <= ST_REPORT;
				end
				ST_REPORT:
				begin
					if (done_ready)
						state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// addresses, data and the completion fields
	always_ff @(posedge CLK)
	begin
		if (cmd_valid && cmd_ready)
		begin
			cur_addr <= cmd_addr;
			rd_section <= cmd_section;
			sent <= '0;
		end
		if (rd_en)
		begin
			cur_addr <= cur_addr + 1'b1;
			sent <= sent + 1'b1;
			last_intr <= rd_entry.intr;
			last_ancill <= rd_entry.ancill;
			if (cur_addr[0])
			begin
				req_addr <= {cur_addr[`LSAB_ADDR_W-1:1], 1'b0};
				req_data <= {rd_entry.data, half_valid ? half_data : {`LSAB_DATA_W{1'b0}}};
				req_be <= {2'b11, {2{half_valid}}};
			end
			else
				half_data <= rd_entry.data;
		end
		// trailing even word goes out alone
		if (flush_now)
		begin
			req_addr <= {cur_addr[`LSAB_ADDR_W-1:1], 1'b0};
			req_data <= {{`LSAB_DATA_W{1'b0}}, half_data};
			req_be <= 4'b0011;
		end
	end

	assign done_valid = (state == ST_REPORT);
	assign done = '{count: sent, abrupt: abrupt_q, intr: last_intr, ancill: last_ancill};

	a_count_nonzero: assert property (@(posedge CLK) disable iff (!RST)
		(cmd_valid && cmd_ready) |-> (cmd_count != '0));

	// a stalled request keeps its contents until the arbiter takes it
	a_req_stable: assert property (@(posedge CLK) disable iff (!RST)
		(req_valid && !req_ready) |=>
		(req_valid && $stable(req_addr) && $stable(req_data) && $stable(req_be)));

endmodule

// File: compile.f
+incdir+.
lsab_pkg.sv
lsab_buffer.sv
block_mover.sv
mcu_arbiter.sv
mvblck_subsys.sv
tb_mvblck.sv

// File: lsab_buffer.sv
// *********************************************************************
// LSAB section FIFOs
// *********************************************************************
`timescale 1ns/10ps
`include "lsab_consts.svh"

module lsab_buffer
(
	input  logic CLK,
	input  logic RST,
	input  logic wr_valid,
	input  logic [`LSAB_SECT_W-1:0] wr_section,
	input  lsab_pkg::lsab_entry_t wr_entry,
	output logic wr_ready,
	input  logic [`LSAB_SECT_W-1:0] rd0_section,
	input  logic rd0_en,
	output lsab_pkg::lsab_entry_t rd0_entry,
	output logic rd0_empty,
	input  logic [`LSAB_SECT_W-1:0] rd1_section,
	input  logic rd1_en,
	output lsab_pkg::lsab_entry_t rd1_entry,
	output logic rd1_empty
);

	localparam int IDX_W = $clog2(`LSAB_DEPTH);

	lsab_pkg::lsab_entry_t mem [`LSAB_SECTIONS][`LSAB_DEPTH];

	// pointers carry one wrap bit above the index
	logic [IDX_W:0] wr_ptr [`LSAB_SECTIONS];
	logic [IDX_W:0] rd_ptr [`LSAB_SECTIONS];
	logic [`LSAB_SECTIONS-1:0] full;
	logic [`LSAB_SECTIONS-1:0] empty;

	// holds writes off until the cycle after reset release
	logic live;
	logic wr_fire;

	always_comb
	begin
		for (int s = 0; s < `LSAB_SECTIONS; s++)
		begin
			empty[s] = (wr_ptr[s] == rd_ptr[s]);
			// same index, opposite lap
			full[s] = (wr_ptr[s][IDX_W] != rd_ptr[s][IDX_W]) &&
				(wr_ptr[s][IDX_W-1:0] == rd_ptr[s][IDX_W-1:0]);
		end
	end

	assign wr_ready = live && !full[wr_section];
	assign wr_fire = wr_valid && wr_ready;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			live <= 1'b0;
			for (int s = 0; s < `LSAB_SECTIONS; s++)
			begin
				wr_ptr[s] <= '0;
				rd_ptr[s] <= '0;
			end
		end
		else
		begin
			live <= 1'b1;
			for (int s = 0; s < `LSAB_SECTIONS; s++)
			begin
				if (wr_fire && wr_section == `LSAB_SECT_W'(s))
					wr_ptr[s] <= wr_ptr[s] + 1'b1;
				// the two ports never pop the same section together
				if ((rd0_en && rd0_section == `LSAB_SECT_W'(s)) ||
					(rd1_en && rd1_section == `LSAB_SECT_W'(s)))
					rd_ptr[s] <= rd_ptr[s] + 1'b1;
			end
		end
	end

	// storage
	always_ff @(posedge CLK)
	begin
		if (wr_fire)
			mem[wr_section][wr_ptr[wr_section][IDX_W-1:0]] <= wr_entry;
	end

	// head of the selected section on each read port
	assign rd0_entry = mem[rd0_section][rd_ptr[rd0_section][IDX_W-1:0]];
	assign rd0_empty = empty[rd0_section];
	assign rd1_entry = mem[rd1_section][rd_ptr[rd1_section][IDX_W-1:0]];
	assign rd1_empty = empty[rd1_section];

	// a mover may only pop a word it has seen
	a_rd0_not_empty: assert property (@(posedge CLK) disable iff (!RST)
		rd0_en |-> !rd0_empty);
	a_rd1_not_empty: assert property (@(posedge CLK) disable iff (!RST)
		rd1_en |-> !rd1_empty);

	// both channels on one section in the same cycle would lose a word
	a_no_shared_pop: assert property (@(posedge CLK) disable iff (!RST)
		(rd0_en && rd1_en) |-> (rd0_section != rd1_section));

endmodule

// File: lsab_consts.svh
// *********************************************************************
// LSAB and block mover sizes
// *********************************************************************
`ifndef LSAB_CONSTS_SVH
`define LSAB_CONSTS_SVH

// word address into DRAM, one LSAB word per address
`define LSAB_ADDR_W 12

// block length in words
`define LSAB_COUNT_W 6

// one LSAB word, a DRAM word holds two of them
`define LSAB_DATA_W 16
`define LSAB_ANCILL_W 25

// section count and its select width
`define LSAB_SECTIONS 4
`define LSAB_SECT_W 2

// words per section, keep this a power of two
`define LSAB_DEPTH 16

`endif

// File: lsab_pkg.sv
// *********************************************************************
// LSAB shared types
// *********************************************************************
`include "lsab_consts.svh"

package lsab_pkg;

	// one stored word with its side information
	typedef struct packed
	{
		logic [`LSAB_DATA_W-1:0] data;
		logic intr;
		logic [`LSAB_ANCILL_W-1:0] ancill;
	} lsab_entry_t;

	// completion record of one block move
	typedef struct packed
	{
		logic [`LSAB_COUNT_W-1:0] count;
		// section ran dry before count words were read
		logic abrupt;
		// flag and tag of the last word taken from the section
		logic intr;
		logic [`LSAB_ANCILL_W-1:0] ancill;
	} mover_done_t;

endpackage

// File: mcu_arbiter.sv
// *********************************************************************
// DRAM write arbiter
// *********************************************************************
`timescale 1ns/10ps
`include "lsab_consts.svh"

module mcu_arbiter
(
	input  logic CLK,
	input  logic RST,
	input  logic req0_valid,
	input  logic [`LSAB_ADDR_W-1:0] req0_addr,
	input  logic [2*`LSAB_DATA_W-1:0] req0_data,
	input  logic [3:0] req0_be,
	output logic req0_ready,
	input  logic req1_valid,
	input  logic [`LSAB_ADDR_W-1:0] req1_addr,
	input  logic [2*`LSAB_DATA_W-1:0] req1_data,
	input  logic [3:0] req1_be,
	output logic req1_ready,
	output logic dram_valid,
	output logic [`LSAB_ADDR_W-1:0] dram_addr,
	output logic [2*`LSAB_DATA_W-1:0] dram_data,
	output logic [3:0] dram_be,
	input  logic dram_ready
);

	// high when channel 1 won last, so channel 0 goes first next
	logic last_grant;
	logic out_free;
	logic grant0;
	logic grant1;

	// the output register takes a new write as the old one drains
	assign out_free = !dram_valid || dram_ready;

	assign grant0 = out_free && req0_valid && (!req1_valid || last_grant);
	assign grant1 = out_free && req1_valid && (!req0_valid || !last_grant);

	assign req0_ready = grant0;
	assign req1_ready = grant1;

	always_ff @(posedge CLK)
	begin
		if (!RST)
		begin
			dram_valid <= 1'b0;
			last_grant <= 1'b0;
		end
		else
		begin
			if (grant0 || grant1)
			begin
				dram_valid <= 1'b1;
				last_grant <= grant1;
			end
			else if (dram_ready)
				dram_valid <= 1'b0;
		end
	end

	// winner's write into the port register
	always_ff @(posedge CLK)
	begin
		if (grant0)
		begin
			dram_addr <= req0_addr;
			dram_data <= req0_data;
			dram_be <= req0_be;
		end
		else if (grant1)
		begin
			dram_addr <= req1_addr;
			dram_data <= req1_data;
			dram_be <= req1_be;
		end
	end

	// one grant per cycle keeps the two channels' writes ordered
	a_one_grant: assert property (@(posedge CLK) disable iff (!RST)
		!(req0_ready && req1_ready));

endmodule

// File: mvblck_subsys.sv
// *********************************************************************
// Block mover subsystem
// *********************************************************************
`timescale 1ns/10ps
`include "lsab_consts.svh"

module mvblck_subsys
(
	input  logic CLK,
	input  logic RST,
	input  logic wr_valid,
	input  logic [`LSAB_SECT_W-1:0] wr_section,
	input  lsab_pkg::lsab_entry_t wr_entry,
	output logic wr_ready,
	input  logic cmd0_valid,
	input  logic [`LSAB_ADDR_W-1:0] cmd0_addr,
	input  logic [`LSAB_COUNT_W-1:0] cmd0_count,
	input  logic [`LSAB_SECT_W-1:0] cmd0_section,
	output logic cmd0_ready,
	input  logic cmd1_valid,
	input  logic [`LSAB_ADDR_W-1:0] cmd1_addr,
	input  logic [`LSAB_COUNT_W-1:0] cmd1_count,
	input  logic [`LSAB_SECT_W-1:0] cmd1_section,
	output logic cmd1_ready,
	output logic dram_valid,
	output logic [`LSAB_ADDR_W-1:0] dram_addr,
	output logic [2*`LSAB_DATA_W-1:0] dram_data,
	output logic [3:0] dram_be,
	input  logic dram_ready,
	output logic done0_valid,
	output lsab_pkg::mover_done_t done0,
	input  logic done0_ready,
	output logic done1_valid,
	output lsab_pkg::mover_done_t done1,
	input  logic done1_ready
);

	logic [`LSAB_SECT_W-1:0] rd0_section, rd1_section;
	logic rd0_en, rd1_en, rd0_empty, rd1_empty;
	lsab_pkg::lsab_entry_t rd0_entry, rd1_entry;
	logic req0_valid, req0_ready, req1_valid, req1_ready;
	logic [`LSAB_ADDR_W-1:0] req0_addr, req1_addr;
	logic [2*`LSAB_DATA_W-1:0] req0_data, req1_data;
	logic [3:0] req0_be, req1_be;

	lsab_buffer u_lsab_buffer (.CLK(CLK), .RST(RST), .wr_valid(wr_valid),
		.wr_section(wr_section), .wr_entry(wr_entry), .wr_ready(wr_ready),
		.rd0_section(rd0_section), .rd0_en(rd0_en), .rd0_entry(rd0_entry),
		.rd0_empty(rd0_empty), .rd1_section(rd1_section), .rd1_en(rd1_en),
		.rd1_entry(rd1_entry), .rd1_empty(rd1_empty));

	block_mover u_mover0 (.CLK(CLK), .RST(RST), .cmd_valid(cmd0_valid),
		.cmd_addr(cmd0_addr), .cmd_count(cmd0_count), .cmd_section(cmd0_section),
		.cmd_ready(cmd0_ready), .rd_section(rd0_section), .rd_en(rd0_en),
		.rd_entry(rd0_entry), .rd_empty(rd0_empty), .req_valid(req0_valid),
		.req_addr(req0_addr), .req_data(req0_data), .req_be(req0_be),
		.req_ready(req0_ready), .done_valid(done0_valid), .done(done0),
		.done_ready(done0_ready));

	block_mover u_mover1 (.CLK(CLK), .RST(RST), .cmd_valid(cmd1_valid),
		.cmd_addr(cmd1_addr), .cmd_count(cmd1_count), .cmd_section(cmd1_section),
		.cmd_ready(cmd1_ready), .rd_section(rd1_section), .rd_en(rd1_en),
		.rd_entry(rd1_entry), .rd_empty(rd1_empty), .req_valid(req1_valid),
		.req_addr(req1_addr), .req_data(req1_data), .req_be(req1_be),
		.req_ready(req1_ready), .done_valid(done1_valid), .done(done1),
		.done_ready(done1_ready));

	mcu_arbiter u_mcu_arbiter (.CLK(CLK), .RST(RST),
		.req0_valid(req0_valid), .req0_addr(req0_addr), .req0_data(req0_data),
		.req0_be(req0_be), .req0_ready(req0_ready),
		.req1_valid(req1_valid), .req1_addr(req1_addr), .req1_data(req1_data),
		.req1_be(req1_be), .req1_ready(req1_ready),
		.dram_valid(dram_valid), .dram_addr(dram_addr), .dram_data(dram_data),
		.dram_be(dram_be), .dram_ready(dram_ready));

endmodule

// File: tb_mvblck.sv
// *********************************************************************
// Block mover subsystem testbench
// *********************************************************************
`timescale 1ns/10ps
`include "lsab_consts.svh"

module tb_mvblck;

	localparam int N_ROWS = 11;
	localparam int MEM_WORDS = 1 << `LSAB_ADDR_W;

	logic CLK;
	logic RST;
	logic wr_valid;
	logic [`LSAB_SECT_W-1:0] wr_section;
	lsab_pkg::lsab_entry_t wr_entry;
	logic wr_ready;
	logic cmd0_valid;
	logic [`LSAB_ADDR_W-1:0] cmd0_addr;
	logic [`LSAB_COUNT_W-1:0] cmd0_count;
	logic [`LSAB_SECT_W-1:0] cmd0_section;
	logic cmd0_ready;
	logic cmd1_valid;
	logic [`LSAB_ADDR_W-1:0] cmd1_addr;
	logic [`LSAB_COUNT_W-1:0] cmd1_count;
	logic [`LSAB_SECT_W-1:0] cmd1_section;
	logic cmd1_ready;
	logic dram_valid;
	logic [`LSAB_ADDR_W-1:0] dram_addr;
	logic [2*`LSAB_DATA_W-1:0] dram_data;
	logic [3:0] dram_be;
	logic dram_ready;
	logic done0_valid;
	lsab_pkg::mover_done_t done0;
	logic done0_ready;
	logic done1_valid;
	lsab_pkg::mover_done_t done1;
	logic done1_ready;

	// one row per test where a paired row runs together with the next one
	string t_name [N_ROWS];
	int t_chan [N_ROWS];
	int t_sect [N_ROWS];
	int t_pre [N_ROWS];
	int t_addr [N_ROWS];
	int t_count [N_ROWS];
	bit t_bp [N_ROWS];
	bit t_pair [N_ROWS];
	int t_hold [N_ROWS];

	// DRAM model and its expected image with one LSAB word per entry
	logic [`LSAB_DATA_W-1:0] dram_mem [MEM_WORDS];
	logic [`LSAB_DATA_W-1:0] exp_mem [MEM_WORDS];

	logic [15:0] lfsr;
	bit bp_on;
	int cycles;
	int cycle_limit;
	int errors;
	int test_errors;
	int tests_passed;
	int tests_failed;

	mvblck_subsys u_mvblck_subsys (.*);

	always #2 CLK = ~CLK;

	task automatic set_row(input int r, input string name, input int chan, input int sect,
		input int pre, input int addr, input int count, input bit bp, input bit pair,
		input int hold);
		t_name[r] = name;
		t_chan[r] = chan;
		t_sect[r] = sect;
		t_pre[r] = pre;
		t_addr[r] = addr;
		t_count[r] = count;
		t_bp[r] = bp;
		t_pair[r] = pair;
		t_hold[r] = hold;
	endtask

	task automatic load_table();
		//      row name            ch sec pre addr  cnt bp pair hold
		set_row(0, "even_full",     0, 0,  8, 'h100, 8,  0, 0,   0);
		set_row(1, "odd_ends",      1, 1,  8, 'h201, 8,  0, 0,   0);
		set_row(2, "abrupt",        0, 2,  5, 'h300, 9,  0, 0,   0);
		set_row(3, "dual_run",      0, 0, 10, 'h400, 10, 0, 1,   0);
		set_row(4, "dual_run_ch1",  1, 3,  9, 'h481, 9,  0, 0,   0);
		// same shapes again under random DRAM back-pressure
		set_row(5, "bp_even_full",  1, 0,  8, 'h500, 8,  1, 0,   0);
		set_row(6, "bp_odd_ends",   0, 1,  8, 'h601, 8,  1, 0,   0);
		set_row(7, "bp_abrupt",     1, 2,  5, 'h700, 9,  1, 0,   0);
		set_row(8, "bp_dual_run",   0, 0, 10, 'h800, 10, 1, 1,   0);
		set_row(9, "bp_dual_ch1",   1, 3,  9, 'h881, 9,  1, 0,   0);
		set_row(10, "done_hold",    0, 1,  3, 'h901, 3,  0, 0,   12);
	endtask

	function automatic logic [`LSAB_DATA_W-1:0] fill_word(input int a);
		return {4'he, 12'(a)};
	endfunction

	function automatic logic [`LSAB_DATA_W-1:0] word_data(input int r, input int i);
		return 16'(r * 256 + 48 + i);
	endfunction

	function automatic bit word_intr(input int r, input int i);
		return ((r + i) % 3) == 0;
	endfunction

	function automatic logic [`LSAB_ANCILL_W-1:0] word_tag(input int r, input int i);
		return 25'((r << 12) ^ (i * 4951) ^ 'h0abcde);
	endfunction

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	always @(negedge CLK)
	begin
		if (bp_on)
		begin
			lfsr = lfsr_next(lfsr);
			dram_ready = lfsr[0];
		end
		else
			dram_ready = 1'b1;
	end

	// DRAM write port with byte enables
	always @(posedge CLK)
	begin
		if (RST && dram_valid && dram_ready)
		begin
			if (dram_addr[0])
			begin
				$display("DRAM write to odd address %0h", dram_addr);
				test_errors++;
			end
			if (dram_be[0])
				dram_mem[dram_addr][7:0] = dram_data[7:0];
			if (dram_be[1])
				dram_mem[dram_addr][15:8] = dram_data[15:8];
			if (dram_be[2])
				dram_mem[dram_addr | 1'b1][7:0] = dram_data[23:16];
			if (dram_be[3])
				dram_mem[dram_addr | 1'b1][15:8] = dram_data[31:24];
		end
	end

	always @(posedge CLK)
	begin
		cycles++;
		if (cycles > cycle_limit)
		begin
			$display("timeout, the DUT did not finish within %0d cycles", cycle_limit);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic fill_section(input int r);
		bit taken;
		for (int i = 0; i < t_pre[r]; i++)
		begin
			wr_valid = 1'b1;
			wr_section = `LSAB_SECT_W'(t_sect[r]);
			wr_entry = '{data: word_data(r, i), intr: word_intr(r, i), ancill: word_tag(r, i)};
			do
			begin
				// sample the handshake as the buffer sees it on the edge
				@(posedge CLK);
				taken = wr_ready;
				@(negedge CLK);
			end
			while (!taken);
		end
		wr_valid = 1'b0;
	endtask

	// change the ready source away from the falling edge that drives it
	task automatic set_backpressure(input bit on);
		@(posedge CLK);
		bp_on = on;
		@(negedge CLK);
	endtask

	task automatic send_cmds(input int first, input int last);
		bit take0;
		bit take1;
		for (int r = first; r <= last; r++)
		begin
			if (t_chan[r] == 0)
			begin
				cmd0_valid = 1'b1;
				cmd0_addr = `LSAB_ADDR_W'(t_addr[r]);
				cmd0_count = `LSAB_COUNT_W'(t_count[r]);
				cmd0_section = `LSAB_SECT_W'(t_sect[r]);
			end
			else
			begin
				cmd1_valid = 1'b1;
				cmd1_addr = `LSAB_ADDR_W'(t_addr[r]);
				cmd1_count = `LSAB_COUNT_W'(t_count[r]);
				cmd1_section = `LSAB_SECT_W'(t_sect[r]);
			end
		end
		while (cmd0_valid || cmd1_valid)
		begin
			take0 = cmd0_valid && cmd0_ready;
			take1 = cmd1_valid && cmd1_ready;
			@(negedge CLK);
			if (take0)
				cmd0_valid = 1'b0;
			if (take1)
				cmd1_valid = 1'b0;
		end
	endtask

	task automatic collect_done(input int r, output lsab_pkg::mover_done_t got);
		bit held_ok;
		while (!(t_chan[r] == 0 ? done0_valid : done1_valid))
			@(negedge CLK);
		got = (t_chan[r] == 0) ? done0 : done1;
		held_ok = 1'b1;
		// record must sit still and the channel stay busy while not taken
		repeat (t_hold[r])
		begin
			@(negedge CLK);
			if (t_chan[r] == 0)
			begin
				if (!done0_valid || done0 !== got || cmd0_ready)
					held_ok = 1'b0;
			end
			else if (!done1_valid || done1 !== got || cmd1_ready)
				held_ok = 1'b0;
		end
		if (!held_ok)
		begin
			$display("%s: done record changed or the mover was ready for a command while held",
				t_name[r]);
			test_errors++;
		end
		if (t_chan[r] == 0)
			done0_ready = 1'b1;
		else
			done1_ready = 1'b1;
		@(negedge CLK);
		done0_ready = 1'b0;
		done1_ready = 1'b0;
	endtask

	task automatic check_done(input int r, input lsab_pkg::mover_done_t got);
		int n;
		lsab_pkg::mover_done_t want;
		n = (t_pre[r] < t_count[r]) ? t_pre[r] : t_count[r];
		want = '{count: `LSAB_COUNT_W'(n), abrupt: (t_pre[r] < t_count[r]),
			intr: word_intr(r, n - 1), ancill: word_tag(r, n - 1)};
		if (got !== want)
		begin
			$display("** Error %s: done expected %h actual %h", t_name[r], want, got);
			test_errors++;
		end
		// word i lands at start plus i
		for (int i = 0; i < n; i++)
			exp_mem[t_addr[r] + i] = word_data(r, i);
	endtask

	task automatic check_memory(input int first);
		for (int a = 0; a < MEM_WORDS; a++)
		begin
			if (dram_mem[a] !== exp_mem[a])
			begin
				if (test_errors < 10)
					$display("** Error %s: word %0h expected %h actual %h",
						t_name[first], a, exp_mem[a], dram_mem[a]);
				test_errors++;
			end
		end
	endtask

	initial
	begin
		lsab_pkg::mover_done_t got0;
		lsab_pkg::mover_done_t got1;
		int first;
		int last;
		int words;
		CLK = 1'b0;
		RST = 1'b0;
		wr_valid = 1'b0;
		wr_section = '0;
		wr_entry = '0;
		cmd0_valid = 1'b0;
		cmd0_addr = '0;
		cmd0_count = '0;
		cmd0_section = '0;
		cmd1_valid = 1'b0;
		cmd1_addr = '0;
		cmd1_count = '0;
		cmd1_section = '0;
		dram_ready = 1'b1;
		done0_ready = 1'b0;
		done1_ready = 1'b0;
		lfsr = 16'd42155;
		bp_on = 1'b0;
		errors = 0;
		test_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		load_table();
		words = 0;
		for (int r = 0; r < N_ROWS; r++)
			words += t_pre[r];
		cycle_limit = 40 * words + 200;
		for (int a = 0; a < MEM_WORDS; a++)
		begin
			dram_mem[a] = fill_word(a);
			exp_mem[a] = fill_word(a);
		end
		repeat (10) @(negedge CLK);
		RST = 1'b1;
		@(negedge CLK);
		first = 0;
		while (first < N_ROWS)
		begin
			last = t_pair[first] ? first + 1 : first;
			test_errors = 0;
			for (int r = first; r <= last; r++)
				fill_section(r);
			set_backpressure(t_bp[first]);
			send_cmds(first, last);
			collect_done(first, got0);
			if (last != first)
				collect_done(last, got1);
			// last write may still sit in the arbiter register
			while (dram_valid)
				@(negedge CLK);
			set_backpressure(1'b0);
			check_done(first, got0);
			if (last != first)
				check_done(last, got1);
			check_memory(first);
			if (test_errors == 0)
			begin
				$display("%s: pass", t_name[first]);
				tests_passed++;
			end
			else
			begin
				$display("%s: FAIL with %0d mismatches", t_name[first], test_errors);
				tests_failed++;
			end
			errors += test_errors;
			first = last + 1;
		end
		$display("tests passed %0d, failed %0d, mismatches %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule
